// ==== common/attn_pkg.sv ====
// Attention score shared definitions

package attn_pkg;

    // ----------------------------------------------------------
    // Fixed widths
    // ----------------------------------------------------------

    // Width of the opcode field in a host command
    localparam int CMD_OP_WIDTH = 3;

    // One signed query or key element
    localparam int ELEM_WIDTH = 8;

    // Dot-product accumulator wide enough for any practical embedding size
    localparam int ACC_WIDTH = 32;

    // Scaled and saturated score as seen by the host
    localparam int SCORE_WIDTH = 16;

    // ----------------------------------------------------------
    // Host opcodes
    // ----------------------------------------------------------

    // Codes 5 to 7 are not listed and count as illegal in the decoder
    typedef enum logic [CMD_OP_WIDTH-1:0] {
        OP_NOP     = 3'd0,
        OP_LOAD_Q  = 3'd1,
        OP_START   = 3'd2,
        OP_KEY     = 3'd3,
        OP_RELEASE = 3'd4
    } cmd_op_e;

endpackage

// ==== logic/cmd_decoder.sv ====
// Host command decoder

`timescale 1ns/1ps

module cmd_decoder #(
    parameter int EMBED_DIM = 4
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cmd_valid,
    input  attn_pkg::cmd_op_e                       cmd_op,
    input  logic [EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0] cmd_data,
    output logic                                    load_valid,
    output logic [EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0] load_data,
    output logic                                    compute_start,
    output logic                                    compute_done,
    output logic                                    key_valid,
    output logic [EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0] key_data,
    output logic                                    cmd_error
);

    // ----------------------------------------------------------
    // Strobe decode
    // ----------------------------------------------------------

    // Every strobe is a single-cycle pulse one cycle behind the command
    // At most one of them is high in any cycle since the opcodes are exclusive
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_valid    <= 1'b0;
            compute_start <= 1'b0;
            compute_done  <= 1'b0;
            key_valid     <= 1'b0;
            cmd_error     <= 1'b0;
        end else begin
            load_valid    <= 1'b0;
            compute_start <= 1'b0;
            compute_done  <= 1'b0;
            key_valid     <= 1'b0;
            if (cmd_valid) begin
                case (cmd_op)
                    attn_pkg::OP_NOP:     ;
                    attn_pkg::OP_LOAD_Q:  load_valid    <= 1'b1;
                    attn_pkg::OP_START:   compute_start <= 1'b1;
                    attn_pkg::OP_KEY:     key_valid     <= 1'b1;
                    attn_pkg::OP_RELEASE: compute_done  <= 1'b1;
                    // Codes 5 to 7 raise the error flag, which holds until reset
                    default:              cmd_error     <= 1'b1;
                endcase
            end
        end
    end

    // ----------------------------------------------------------
    // Data routing
    // ----------------------------------------------------------

    // The data word is captured only beside the strobe that consumes it,
    // so a key does not disturb a pending query row and vice versa
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_op == attn_pkg::OP_LOAD_Q) begin
            load_data <= cmd_data;
        end
        if (cmd_valid && cmd_op == attn_pkg::OP_KEY) begin
            key_data <= cmd_data;
        end
    end

endmodule

// ==== q_buffer/q_bank_buffer.sv ====
// Ping-pong query bank buffer

`timescale 1ns/1ps

module q_bank_buffer #(
    parameter int NUM_PES   = 4,
    parameter int EMBED_DIM = 4
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            load_valid,
    input  logic [EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0]         load_data,
    input  logic                                            compute_start,
    input  logic                                            compute_done,
    output logic                                            load_ready,
    output logic                                            bank_ready,
    output logic                                            bank_active,
    output logic [NUM_PES*EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0] q_to_pes
);

    localparam int ROW_W = EMBED_DIM * attn_pkg::ELEM_WIDTH;
    // Keep the index at least one bit wide for a single-row bank
    localparam int IDX_W = (NUM_PES > 1) ? $clog2(NUM_PES) : 1;

    // Two banks with one row per processing element
    logic [ROW_W-1:0] bank0 [NUM_PES];
    logic [ROW_W-1:0] bank1 [NUM_PES];

    logic             fill_bank;
    logic [IDX_W-1:0] wr_idx;
    logic             bank0_full;
    logic             bank1_full;
    logic             active_bank;
    logic             active_valid;

    logic             fill_full;
    logic             load_accept;
    logic             bank0_rdy;
    logic             bank1_rdy;

    // ----------------------------------------------------------
    // Status levels
    // ----------------------------------------------------------

    // Loads go through only while the current fill bank has room
    assign fill_full   = fill_bank ? bank1_full : bank0_full;
    assign load_ready  = !fill_full;
    assign load_accept = load_valid && !fill_full;

    // A bank can be started when it is full and not already in use
    assign bank0_rdy = bank0_full && !(active_valid && !active_bank);
    assign bank1_rdy = bank1_full && !(active_valid && active_bank);

    assign bank_ready  = bank0_rdy || bank1_rdy;
    assign bank_active = active_valid;

    // ----------------------------------------------------------
    // Load side
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_accept) begin
            if (fill_bank) begin
                bank1[wr_idx] <= load_data;
            end else begin
                bank0[wr_idx] <= load_data;
            end
        end
    end

    // A dropped load leaves the index and flags alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_bank  <= 1'b0;
            wr_idx     <= '0;
            bank0_full <= 1'b0;
            bank1_full <= 1'b0;
        end else begin
            if (load_accept) begin
                if (wr_idx == IDX_W'(NUM_PES - 1)) begin
                    // Last row of the bank, so hand filling to the other side
                    wr_idx    <= '0;
                    fill_bank <= ~fill_bank;
                    if (fill_bank) begin
                        bank1_full <= 1'b1;
                    end else begin
                        bank0_full <= 1'b1;
                    end
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end

            // Release frees the active bank for refilling
            if (compute_done && active_valid) begin
                if (active_bank) begin
                    bank1_full <= 1'b0;
                end else begin
                    bank0_full <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Compute side
    // ----------------------------------------------------------

    // Bank 0 wins when both are ready and a start with none ready is ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_bank  <= 1'b0;
            active_valid <= 1'b0;
        end else if (compute_start) begin
            if (bank0_rdy) begin
                active_bank  <= 1'b0;
                active_valid <= 1'b1;
            end else if (bank1_rdy) begin
                active_bank  <= 1'b1;
                active_valid <= 1'b1;
            end
        end else if (compute_done) begin
            active_valid <= 1'b0;
        end
    end

    // Row g of the active bank feeds processing element g
    // With no bank active the elements see zeros and produce zero scores
    for (genvar g = 0; g < NUM_PES; g++) begin : g_pe_out
        assign q_to_pes[g*ROW_W +: ROW_W] = !active_valid ? '0 :
                                            (active_bank ? bank1[g] : bank0[g]);
    end

endmodule

// ==== logic/pe_array.sv ====
// Pipelined int8 dot-product array

`timescale 1ns/1ps

module pe_array #(
    parameter int NUM_PES   = 4,
    parameter int EMBED_DIM = 4
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            key_valid,
    input  logic [EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0]         key_data,
    input  logic [NUM_PES*EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0] q_to_pes,
    output logic                                            acc_valid,
    output logic [NUM_PES*attn_pkg::ACC_WIDTH-1:0]            acc
);

    localparam int EW    = attn_pkg::ELEM_WIDTH;
    localparam int AW    = attn_pkg::ACC_WIDTH;
    localparam int ROW_W = EMBED_DIM * EW;
    localparam int PW    = 2 * EW;

    // Stage one holds every element product of every processing element
    logic signed [PW-1:0] prod_q [NUM_PES][EMBED_DIM];
    logic                 prod_valid;

    // Combinational sums feeding stage two
    logic signed [AW-1:0] sum_d [NUM_PES];

    // ----------------------------------------------------------
    // Stage one: element products
    // ----------------------------------------------------------

    // The key is broadcast to every element and each one uses its own query row
    always_ff @(posedge clk) begin
        if (key_valid) begin
            for (int p = 0; p < NUM_PES; p++) begin
                for (int e = 0; e < EMBED_DIM; e++) begin
                    prod_q[p][e] <= $signed(q_to_pes[p*ROW_W + e*EW +: EW]) *
                                    $signed(key_data[e*EW +: EW]);
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Stage two: reduction
    // ----------------------------------------------------------

    // Each product is sign extended before it is added in
    always_comb begin
        for (int p = 0; p < NUM_PES; p++) begin
            sum_d[p] = '0;
            for (int e = 0; e < EMBED_DIM; e++) begin
                sum_d[p] = sum_d[p] + AW'(prod_q[p][e]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int p = 0; p < NUM_PES; p++) begin
                acc[p*AW +: AW] <= sum_d[p];
            end
        end
    end

    // Valid bit travels beside the two data stages
    // Back-to-back keys simply occupy both stages at once
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            acc_valid  <= 1'b0;
        end else begin
            prod_valid <= key_valid;
            acc_valid  <= prod_valid;
        end
    end

endmodule

// ==== logic/score_collector.sv ====
// Score scaling and running maximum

`timescale 1ns/1ps

module score_collector #(
    parameter int NUM_PES     = 4,
    parameter int SCORE_SHIFT = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   acc_valid,
    input  logic [NUM_PES*attn_pkg::ACC_WIDTH-1:0]   acc,
    input  logic                                   clear,
    output logic                                   score_valid,
    output logic [NUM_PES*attn_pkg::SCORE_WIDTH-1:0] scores,
    output logic [NUM_PES*attn_pkg::SCORE_WIDTH-1:0] row_max
);

    localparam int AW = attn_pkg::ACC_WIDTH;
    localparam int SW = attn_pkg::SCORE_WIDTH;

    // Signed limits of a score held at accumulator width for the compare
    localparam logic signed [AW-1:0] SAT_MAX = AW'((1 << (SW - 1)) - 1);
    localparam logic signed [AW-1:0] SAT_MIN = -AW'(1 << (SW - 1));

    // Whether the maxima hold a real score since the last clear
    typedef enum logic {
        MAX_EMPTY,
        MAX_HELD
    } max_state_e;

    max_state_e           max_state;
    logic signed [AW-1:0] shifted [NUM_PES];
    logic signed [SW-1:0] sat_d   [NUM_PES];

    // ----------------------------------------------------------
    // Scale and saturate
    // ----------------------------------------------------------

    always_comb begin
        for (int r = 0; r < NUM_PES; r++) begin
            shifted[r] = $signed(acc[r*AW +: AW]) >>> SCORE_SHIFT;
            if (shifted[r] > SAT_MAX) begin
                sat_d[r] = SAT_MAX[SW-1:0];
            end else if (shifted[r] < SAT_MIN) begin
                sat_d[r] = SAT_MIN[SW-1:0];
            end else begin
                sat_d[r] = shifted[r][SW-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            for (int r = 0; r < NUM_PES; r++) begin
                scores[r*SW +: SW] <= sat_d[r];
            end
        end
    end

    // ----------------------------------------------------------
    // Running maximum
    // ----------------------------------------------------------

    // A score that lands on the same edge as a clear counts as the first one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            score_valid <= 1'b0;
            row_max     <= '0;
            max_state   <= MAX_EMPTY;
        end else begin
            score_valid <= acc_valid;
            if (acc_valid) begin
                for (int r = 0; r < NUM_PES; r++) begin
                    if (clear || max_state == MAX_EMPTY ||
                        sat_d[r] > $signed(row_max[r*SW +: SW])) begin
                        row_max[r*SW +: SW] <= sat_d[r];
                    end
                end
                max_state <= MAX_HELD;
            end else if (clear) begin
                row_max   <= '0;
                max_state <= MAX_EMPTY;
            end
        end
    end

endmodule

// ==== logic/attn_score_top.sv ====
// Attention score tile top level

`timescale 1ns/1ps

module attn_score_top #(
    parameter int NUM_PES     = 4,
    parameter int EMBED_DIM   = 4,
    parameter int SCORE_SHIFT = 2
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     cmd_valid,
    input  attn_pkg::cmd_op_e                        cmd_op,
    input  logic [EMBED_DIM*attn_pkg::ELEM_WIDTH-1:0]  cmd_data,
    output logic                                     load_ready,
    output logic                                     bank_ready,
    output logic                                     bank_active,
    output logic                                     cmd_error,
    output logic                                     score_valid,
    output logic [NUM_PES*attn_pkg::SCORE_WIDTH-1:0]   scores,
    output logic [NUM_PES*attn_pkg::SCORE_WIDTH-1:0]   row_max
);

    localparam int ROW_W = EMBED_DIM * attn_pkg::ELEM_WIDTH;

    // Decoded strobes and their data words
    logic                                 load_valid;
    logic [ROW_W-1:0]                     load_data;
    logic                                 compute_start;
    logic                                 compute_done;
    logic                                 key_valid;
    logic [ROW_W-1:0]                     key_data;

    // Query rows of the active bank and the raw dot products
    logic [NUM_PES*ROW_W-1:0]             q_to_pes;
    logic                                 acc_valid;
    logic [NUM_PES*attn_pkg::ACC_WIDTH-1:0] acc;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------

    cmd_decoder #(
        .EMBED_DIM (EMBED_DIM)
    ) u_cmd_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_data      (cmd_data),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .compute_start (compute_start),
        .compute_done  (compute_done),
        .key_valid     (key_valid),
        .key_data      (key_data),
        .cmd_error     (cmd_error)
    );

    // ----------------------------------------------------------
    // Query storage, execute and result
    // ----------------------------------------------------------

    q_bank_buffer #(
        .NUM_PES   (NUM_PES),
        .EMBED_DIM (EMBED_DIM)
    ) u_q_bank_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .compute_start (compute_start),
        .compute_done  (compute_done),
        .load_ready    (load_ready),
        .bank_ready    (bank_ready),
        .bank_active   (bank_active),
        .q_to_pes      (q_to_pes)
    );

    pe_array #(
        .NUM_PES   (NUM_PES),
        .EMBED_DIM (EMBED_DIM)
    ) u_pe_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_data  (key_data),
        .q_to_pes  (q_to_pes),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    // Each start clears the running maxima for the new bank
    score_collector #(
        .NUM_PES     (NUM_PES),
        .SCORE_SHIFT (SCORE_SHIFT)
    ) u_score_collector (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_valid   (acc_valid),
        .acc         (acc),
        .clear       (compute_start),
        .score_valid (score_valid),
        .scores      (scores),
        .row_max     (row_max)
    );

endmodule

// ==== verif/attn_score_model.svh ====
// Attention score reference model
`ifndef ATTN_SCORE_MODEL_SVH
`define ATTN_SCORE_MODEL_SVH

// ------------------------------------------------------------
// Model state advanced one step per host command
// ------------------------------------------------------------

// Query rows indexed by bank and then by row
logic [ROW_W-1:0] m_bank [2][NUM_PES];
logic             m_full [2];
logic             m_fill;
int               m_idx;
logic             m_act_bank;
logic             m_active;
// Running maxima and whether one is held since the last start
logic [SC_W-1:0]  m_max;
logic             m_held;

function automatic void model_reset();
    m_fill     = 1'b0;
    m_idx      = 0;
    m_full[0]  = 1'b0;
    m_full[1]  = 1'b0;
    m_act_bank = 1'b0;
    m_active   = 1'b0;
    m_max      = '0;
    m_held     = 1'b0;
endfunction

// A bank can be started when it is full and not the one in use
function automatic logic can_start(input logic b);
    return m_full[b] && !(m_active && m_act_bank == b);
endfunction

// Levels as {load_ready, bank_ready, bank_active}
function automatic logic [2:0] model_status();
    return {!m_full[m_fill], can_start(1'b0) || can_start(1'b1), m_active};
endfunction

function automatic void model_load(input logic [ROW_W-1:0] row);
    // A load into a full fill bank is dropped
    if (m_full[m_fill]) begin
        return;
    end
    m_bank[m_fill][m_idx] = row;
    if (m_idx == NUM_PES - 1) begin
        m_full[m_fill] = 1'b1;
        m_idx          = 0;
        m_fill         = !m_fill;
    end else begin
        m_idx++;
    end
endfunction

// Bank 0 is preferred and the maxima clear even when no bank is ready
function automatic void model_start();
    if (can_start(1'b0)) begin
        m_act_bank = 1'b0;
        m_active   = 1'b1;
    end else if (can_start(1'b1)) begin
        m_act_bank = 1'b1;
        m_active   = 1'b1;
    end
    m_max  = '0;
    m_held = 1'b0;
endfunction

function automatic void model_release();
    if (m_active) begin
        m_full[m_act_bank] = 1'b0;
        m_active           = 1'b0;
    end
endfunction

// Dot product per row, arithmetic shift, then clamp to the score range
function automatic logic [SC_W-1:0] model_scores(input logic [ROW_W-1:0] key);
    logic [ROW_W-1:0] q;
    logic [SC_W-1:0]  res;
    int               dot;
    int               sc;
    for (int p = 0; p < NUM_PES; p++) begin
        q   = m_active ? m_bank[m_act_bank][p] : '0;
        dot = 0;
        for (int e = 0; e < EMBED_DIM; e++) begin
            dot = dot + $signed(q[e*EW +: EW]) * $signed(key[e*EW +: EW]);
        end
        sc = dot >>> SCORE_SHIFT;
        if (sc > SCORE_HI) begin
            sc = SCORE_HI;
        end else if (sc < SCORE_LO) begin
            sc = SCORE_LO;
        end
        res[p*SW +: SW] = SW'(sc);
    end
    return res;
endfunction

function automatic void model_update_max(input logic [SC_W-1:0] sc);
    for (int p = 0; p < NUM_PES; p++) begin
        if (!m_held || $signed(sc[p*SW +: SW]) > $signed(m_max[p*SW +: SW])) begin
            m_max[p*SW +: SW] = sc[p*SW +: SW];
        end
    end
    m_held = 1'b1;
endfunction

`endif

// ==== verif/tb_attn_score.sv ====
// Attention score tile testbench

`timescale 1ns/1ps

module tb_attn_score;

    localparam int NUM_PES     = 4;
    localparam int EMBED_DIM   = 4;
    localparam int SCORE_SHIFT = 2;
    localparam int EW          = attn_pkg::ELEM_WIDTH;
    localparam int SW          = attn_pkg::SCORE_WIDTH;
    localparam int ROW_W       = EMBED_DIM * EW;
    localparam int SC_W        = NUM_PES * SW;
    localparam int SCORE_HI    = (1 << (SW - 1)) - 1;
    localparam int SCORE_LO    = -(1 << (SW - 1));
    // A key command driven in cycle k shows its scores in cycle k+4
    localparam int KEY_DUE     = 4;
    localparam int DRAIN_LIMIT = 20;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              cmd_valid;
    attn_pkg::cmd_op_e cmd_op;
    logic [ROW_W-1:0]  cmd_data;
    logic              load_ready;
    logic              bank_ready;
    logic              bank_active;
    logic              cmd_error;
    logic              score_valid;
    logic [SC_W-1:0]   scores;
    logic [SC_W-1:0]   row_max;

    int cyc = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int err_base = 0;

    // Outstanding keys and the status levels still in flight
    int              due_q[$];
    logic [SC_W-1:0] score_q[$];
    logic [2:0]      status_q[$];

    `include "attn_score_model.svh"

    attn_score_top DUT (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input logic [255:0] expected, input logic [255:0] actual,
                               input string what);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Score monitor sampled on the falling edge
    // ------------------------------------------------------------

    always @(negedge clk) begin : score_monitor
        logic [SC_W-1:0] exp_sc;
        if (rst_n) begin
            if (due_q.size() > 0 && due_q[0] < cyc) begin
                errors++;
                $display("Error: no score arrived for the key due in cycle %0d", due_q[0]);
                void'(due_q.pop_front());
                void'(score_q.pop_front());
            end
            if (score_valid && due_q.size() == 0) begin
                errors++;
                $display("Error: score_valid went high with no key outstanding");
            end else if (score_valid) begin
                check_value(due_q.pop_front(), cyc, "score latency");
                exp_sc = score_q.pop_front();
                model_update_max(exp_sc);
                check_value(exp_sc, scores, "scores");
                check_value(m_max, row_max, "row_max");
            end
        end
    end

    // ------------------------------------------------------------
    // Command driver
    // ------------------------------------------------------------

    // Levels seen now reflect the command driven two cycles earlier
    task automatic send_cmd(input logic valid, input attn_pkg::cmd_op_e op,
                            input logic [ROW_W-1:0] data);
        @(negedge clk);
        check_value(status_q.pop_front(), {load_ready, bank_ready, bank_active},
                    "load_ready, bank_ready, bank_active");
        cmd_valid = valid;
        cmd_op    = op;
        cmd_data  = data;
        if (valid) begin
            case (op)
                attn_pkg::OP_LOAD_Q:  model_load(data);
                attn_pkg::OP_START:   model_start();
                attn_pkg::OP_RELEASE: model_release();
                attn_pkg::OP_KEY: begin
                    due_q.push_back(cyc + KEY_DUE);
                    score_q.push_back(model_scores(data));
                end
                default: ;
            endcase
        end
        status_q.push_back(model_status());
    endtask

    task automatic idle(input int n);
        repeat (n) send_cmd(1'b0, attn_pkg::OP_NOP, '0);
    endtask

    task automatic send_key(input logic [ROW_W-1:0] key);
        send_cmd(1'b1, attn_pkg::OP_KEY, key);
    endtask

    function automatic logic [ROW_W-1:0] random_row();
        return ROW_W'($urandom);
    endfunction

    task automatic drain_scores();
        int waited;
        waited = 0;
        while (due_q.size() > 0 && waited < DRAIN_LIMIT) begin
            idle(1);
            waited++;
        end
        if (due_q.size() > 0) begin
            errors++;
            $display("Timeout: %0d keys still had no scores after %0d cycles",
                     due_q.size(), DRAIN_LIMIT);
        end
    endtask

    task automatic reset_dut();
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = attn_pkg::OP_NOP;
        cmd_data  = '0;
        model_reset();
        due_q.delete();
        score_q.delete();
        status_q.delete();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) status_q.push_back(model_status());
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d (%s) finished with %0d errors", tests, name, errors - err_base);
        err_base = errors;
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin : main
        int r;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = attn_pkg::OP_NOP;
        cmd_data  = '0;
        void'($urandom(52214));
        reset_dut();

        // Both banks fill, then two extra rows are dropped
        for (int i = 0; i < 2 * NUM_PES + 2; i++) begin
            send_cmd(1'b1, attn_pkg::OP_LOAD_Q, random_row());
        end
        idle(2);
        check_value(0, load_ready, "load_ready with both banks full");
        check_value(1, bank_ready, "bank_ready with both banks full");
        end_test("fill and ping-pong");

        // Bank 0 first, bank 1 after the release, then a start with nothing ready
        send_cmd(1'b1, attn_pkg::OP_START, '0);
        idle(2);
        check_value(1, bank_ready, "bank_ready with bank 1 still waiting");
        send_cmd(1'b1, attn_pkg::OP_RELEASE, '0);
        idle(2);
        check_value(0, bank_active, "bank_active after release");
        send_cmd(1'b1, attn_pkg::OP_START, '0);
        send_cmd(1'b1, attn_pkg::OP_START, '0);
        idle(2);
        check_value(1, bank_active, "bank_active after an ignored start");
        check_value(0, bank_ready, "bank_ready with no bank left");
        end_test("activation and release");

        // Extreme rows go into bank 0 while bank 1 serves back-to-back keys
        send_cmd(1'b1, attn_pkg::OP_LOAD_Q, {4{8'h7f}});
        send_cmd(1'b1, attn_pkg::OP_LOAD_Q, {4{8'h80}});
        send_cmd(1'b1, attn_pkg::OP_LOAD_Q, {8'h7f, 8'h80, 8'h7f, 8'h80});
        send_cmd(1'b1, attn_pkg::OP_LOAD_Q, random_row());
        repeat (6) send_key(random_row());
        drain_scores();
        send_cmd(1'b1, attn_pkg::OP_RELEASE, '0);
        send_cmd(1'b1, attn_pkg::OP_START, '0);
        send_key({4{8'h80}});
        send_key({4{8'h7f}});
        send_key({8'h80, 8'h7f, 8'h80, 8'h7f});
        repeat (8) begin
            send_key(random_row());
            if ($urandom % 3 == 0) begin
                idle(1);
            end
        end
        drain_scores();
        end_test("scores");

        send_cmd(1'b1, attn_pkg::OP_RELEASE, '0);
        repeat (3) send_key(random_row());
        drain_scores();
        check_value(0, scores, "scores with no active bank");
        end_test("inactive keys");

        // Weighted random commands with the pending scores drained before every start
        repeat (80) begin
            r = $urandom % 20;
            if (r < 2) begin
                idle(1);
            end else if (r < 3) begin
                send_cmd(1'b1, attn_pkg::OP_NOP, random_row());
            end else if (r < 9) begin
                send_cmd(1'b1, attn_pkg::OP_LOAD_Q, random_row());
            end else if (r < 15) begin
                send_key(random_row());
            end else if (r < 17) begin
                drain_scores();
                send_cmd(1'b1, attn_pkg::OP_START, '0);
                idle(2);
                check_value(m_max, row_max, "row_max cleared by start");
            end else begin
                send_cmd(1'b1, attn_pkg::OP_RELEASE, '0);
            end
        end
        drain_scores();
        end_test("running maximum");

        check_value(0, cmd_error, "cmd_error before illegal opcodes");
        for (int c = 5; c < 8; c++) begin
            send_cmd(1'b1, attn_pkg::cmd_op_e'(c), random_row());
            idle(1);
        end
        idle(2);
        check_value(1, cmd_error, "cmd_error after illegal opcodes");
        send_key(random_row());
        send_cmd(1'b1, attn_pkg::OP_LOAD_Q, random_row());
        drain_scores();
        check_value(1, cmd_error, "cmd_error held after legal commands");
        reset_dut();
        idle(1);
        check_value(0, cmd_error, "cmd_error after reset");
        end_test("illegal opcodes");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== attn_score.f ====
+incdir+verif
common/attn_pkg.sv
logic/cmd_decoder.sv
q_buffer/q_bank_buffer.sv
logic/pe_array.sv
logic/score_collector.sv
logic/attn_score_top.sv
verif/tb_attn_score.sv
